// File: filelist.f
source/core_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/result_unit.sv
source/core_top.sv
test/clock_gen.sv
test/core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and check the log.
set -e

verilator --binary --timing -j 0 --top-module core_tb -f filelist.f -o core_sim
./obj_dir/core_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
  exit 0
else
  exit 1
fi

// File: test/core_tb.sv
// Core testbench: AXI4-Lite instruction memory, reference model, compare tasks and timeouts.
`timescale 1ns/1ps

module core_tb;
  import core_pkg::*;

  localparam int timeout_cycles = 400;
  localparam int halt_window = 40;

  logic clk;
  logic por_reset;
  logic tb_reset = 1'b1;
  logic rst;
  logic arvalid;
  logic arready = 1'b0;
  axi_ar_t ar;
  logic rvalid = 1'b0;
  logic rready;
  axi_r_t r = '0;
  logic retire_valid;
  retire_t retire;

  logic [31:0] prog [64];
  logic [63:0] err_addr = '1;  // Address answered with SLVERR.
  logic [63:0] model_regs [32];
  logic [63:0] model_pc;
  logic [31:0] lcg_state = 32'h2844_ab18;
  int errors = 0;
  int checks = 0;
  int ar_count = 0;
  int retire_count = 0;
  bit timed_out = 1'b0;
  string test_name = "reset";

  logic [1:0] ar_delay;
  logic [1:0] r_delay;
  logic r_pending;
  logic [63:0] req_addr;
  logic ar_hold;
  axi_ar_t ar_prev;

  assign rst = por_reset | tb_reset;

  clock_gen clocks (
    .clk   (clk),
    .reset (por_reset)
  );

  core_top dut (
    .clk          (clk),
    .reset        (rst),
    .arvalid      (arvalid),
    .arready      (arready),
    .ar           (ar),
    .rvalid       (rvalid),
    .rready       (rready),
    .r            (r),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  function automatic logic [1:0] next_delay();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[17:16];  // Upper bits have the longer period.
  endfunction

  function automatic logic [31:0] word_at(input logic [63:0] addr);
    if (addr == err_addr) begin
      return 32'h0;  // The core sees an error response as a zero word.
    end
    return prog[addr[7:2]];
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] enc_i(input int imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    logic [11:0] i;
    i = imm[11:0];
    return {i, rs1, f3, rd, opc_op_imm};
  endfunction

  function automatic logic [31:0] enc_b(input int off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    logic [12:0] o;
    o = off[12:0];
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], opc_branch};
  endfunction

  function automatic logic [31:0] enc_j(input int off, input logic [4:0] rd);
    logic [20:0] o;
    o = off[20:0];
    return {o[20], o[10:1], o[11], o[19:12], rd, opc_jal};
  endfunction

  // Architectural model of one instruction, straight from the RV64I rules.
  function automatic retire_t model_step(input logic [63:0] pc, input logic [31:0] w);
    retire_t e;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm;
    e = '0;
    e.pc = pc;
    e.rd = w[11:7];
    e.next_pc = pc + 64'd4;
    a = model_regs[w[19:15]];
    b = model_regs[w[24:20]];
    case (w[6:0])
      opc_op: begin
        e.reg_write = 1'b1;
        case ({w[31:25], w[14:12]})
          10'h000: e.value = a + b;
          10'h100: e.value = a - b;
          10'h002: e.value = {63'b0, $signed(a) < $signed(b)};
          10'h004: e.value = a ^ b;
          10'h006: e.value = a | b;
          10'h007: e.value = a & b;
          default: e.fault = 1'b1;
        endcase
      end
      opc_op_imm: begin
        e.reg_write = 1'b1;
        imm = {{52{w[31]}}, w[31:20]};
        case (w[14:12])
          3'd0: e.value = a + imm;
          3'd4: e.value = a ^ imm;
          3'd6: e.value = a | imm;
          3'd7: e.value = a & imm;
          default: e.fault = 1'b1;
        endcase
      end
      opc_lui: begin
        e.reg_write = 1'b1;
        e.value = {{32{w[31]}}, w[31:12], 12'b0};
      end
      opc_branch: begin
        imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        if (w[14:12] == 3'd0) begin
          e.next_pc = (a == b) ? pc + imm : pc + 64'd4;
        end else if (w[14:12] == 3'd1) begin
          e.next_pc = (a != b) ? pc + imm : pc + 64'd4;
        end else begin
          e.fault = 1'b1;
        end
      end
      opc_jal: begin
        imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        e.reg_write = 1'b1;
        e.value = pc + 64'd4;
        e.next_pc = pc + imm;
      end
      default: e.fault = 1'b1;
    endcase
    if (e.fault) begin
      e.reg_write = 1'b0;
    end
    return e;
  endfunction

  function automatic string retire_text(input retire_t v);
    return $sformatf("pc=%h rd=%0d we=%b val=%h npc=%h f=%b", v.pc, v.rd, v.reg_write,
                     v.value, v.next_pc, v.fault);
  endfunction

  task automatic check_retire(input retire_t exp, input retire_t act);
    logic bad;
    retire_t seen;
    checks++;
    seen = act;
    // Without a register write the value carries no meaning.
    if (!exp.reg_write) begin
      seen.value = exp.value;
    end
    // A faulting instruction is judged by its pc and fault flag alone.
    if (exp.fault) begin
      bad = (act.pc !== exp.pc) || (act.fault !== 1'b1) || (act.reg_write !== 1'b0);
    end else begin
      bad = (seen !== exp);
    end
    if (bad) begin
      errors++;
      $display("Fail %s retire: expected %s actual %s", test_name, retire_text(exp),
               retire_text(act));
    end
  endtask

  task automatic check_ar(input axi_ar_t exp, input axi_ar_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s ar: expected %h/%b actual %h/%b", test_name, exp.araddr, exp.arprot,
               act.araddr, act.arprot);
    end
  endtask

  // Memory model with random AR and R latencies.
  always @(posedge clk) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid <= 1'b0;
      r_pending <= 1'b0;
      ar_delay <= next_delay();
    end else begin
      if (arvalid && arready) begin
        arready <= 1'b0;
        req_addr <= ar.araddr;
        r_delay <= next_delay();
        r_pending <= 1'b1;
      end else if (arvalid && !r_pending) begin
        if (ar_delay == 2'd0) begin
          arready <= 1'b1;
        end else begin
          ar_delay <= ar_delay - 2'd1;
        end
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        r_pending <= 1'b0;
        ar_delay <= next_delay();
      end else if (r_pending && !rvalid) begin
        if (r_delay == 2'd0) begin
          rvalid <= 1'b1;
          r.rdata <= prog[req_addr[7:2]];
          r.rresp <= (req_addr == err_addr) ? 2'b10 : resp_okay;
        end else begin
          r_delay <= r_delay - 2'd1;
        end
      end
    end
  end

  // Checker, which follows the model through every retire and AR transfer.
  always @(posedge clk) begin
    retire_t exp;
    axi_ar_t exp_ar;
    if (rst) begin
      model_pc = reset_pc;
      for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
      end
      ar_count = 0;
      retire_count = 0;
      ar_hold = 1'b0;
    end else begin
      if (retire_valid) begin
        exp = model_step(model_pc, word_at(model_pc));
        check_retire(exp, retire);
        if (ar_count != retire_count + 1) begin
          errors++;
          $display("AR requests (%0d) do not match retired instructions (%0d) in %s",
                   ar_count, retire_count + 1, test_name);
        end
        if (exp.reg_write && exp.rd != 5'd0) begin
          model_regs[exp.rd] = exp.value;
        end
        model_pc = exp.next_pc;
        retire_count++;
      end
      if (rready && !r_pending) begin
        errors++;
        $display("rready is high with no read outstanding in %s", test_name);
      end
      if (ar_hold && (!arvalid || ar !== ar_prev)) begin
        errors++;
        $display("The AR request changed or was dropped before arready in %s", test_name);
      end
      if (arvalid && arready) begin
        exp_ar.araddr = model_pc;
        exp_ar.arprot = insn_arprot;
        check_ar(exp_ar, ar);
        ar_count++;
      end
      ar_hold = arvalid && !arready;
      ar_prev = ar;
    end
  end

  task automatic finish_run();
    $display("Errors: %0d, checks: %0d, timeout: %0d", errors, checks, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic wait_reset_release();
    int n;
    for (n = 0; n < 20 && rst; n++) begin
      @(negedge clk);
    end
    if (rst) begin
      $display("Reset never deasserted");
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_retires(input int count);
    int n;
    for (n = 0; n < timeout_cycles && retire_count < count; n++) begin
      @(negedge clk);
    end
    if (retire_count < count) begin
      $display("Only %0d of %0d instructions retired in %s", retire_count, count, test_name);
      timed_out = 1'b1;
    end
  endtask

  // Reset goes up on a rising edge and stays up while the program memory changes.
  task automatic assert_reset();
    @(posedge clk);
    tb_reset <= 1'b1;
    @(negedge clk);
  endtask

  task automatic release_reset();
    repeat (2) @(posedge clk);
    tb_reset <= 1'b0;
    wait_reset_release();
  endtask

  task automatic fill_memory();
    for (int i = 0; i < 64; i++) begin
      prog[i] = {i[23:0], 8'h7f};  // Unused words are illegal opcodes.
    end
  endtask

  task automatic load_main_program();
    fill_memory();
    prog[0] = enc_i(5, 0, 3'd0, 1);
    prog[1] = enc_i(-3, 0, 3'd0, 2);
    prog[2] = enc_r(7'h00, 2, 1, 3'd0, 3);
    prog[3] = enc_r(7'h20, 1, 2, 3'd0, 4);
    prog[4] = enc_r(7'h00, 1, 2, 3'd2, 5);
    prog[5] = enc_r(7'h00, 2, 1, 3'd2, 6);
    prog[6] = enc_r(7'h00, 2, 1, 3'd7, 7);
    prog[7] = enc_r(7'h00, 2, 1, 3'd6, 8);
    prog[8] = enc_r(7'h00, 2, 1, 3'd4, 9);
    prog[9] = enc_i(-16, 2, 3'd7, 10);
    prog[10] = enc_i(12'h7f0, 1, 3'd6, 11);
    prog[11] = enc_i(-1, 2, 3'd4, 12);
    prog[12] = enc_i(7, 1, 3'd0, 0);
    prog[13] = enc_r(7'h00, 1, 0, 3'd0, 13);
    prog[14] = {20'h80000, 5'd14, opc_lui};
    prog[15] = enc_j(12, 15);
    prog[18] = enc_b(8, 1, 1, 3'd0);  // Taken forward BEQ.
    prog[20] = enc_b(8, 1, 1, 3'd1);
    prog[21] = enc_b(8, 2, 1, 3'd0);
    prog[22] = enc_b(8, 2, 1, 3'd1);
    prog[24] = enc_i(3, 0, 3'd0, 19);
    prog[25] = enc_i(1, 16, 3'd0, 16);
    prog[26] = enc_b(-4, 19, 16, 3'd1);  // Backward loop, three passes.
    prog[27] = enc_j(0, 21);
  endtask

  task automatic run_tests();
    load_main_program();
    @(posedge clk);
    tb_reset <= 1'b0;
    wait_reset_release();
    if (timed_out) begin
      return;
    end
    test_name = "main program";
    if (retire_valid !== 1'b0 || arvalid !== 1'b1) begin
      errors++;
      $display("Core outputs are wrong in the first cycle after reset");
    end
    wait_retires(30);
    if (timed_out) begin
      return;
    end

    test_name = "illegal word";
    assert_reset();
    fill_memory();
    prog[0] = enc_i(1, 0, 3'd0, 1);
    prog[1] = 32'hffff_ffff;
    release_reset();
    if (timed_out) begin
      return;
    end
    wait_retires(2);
    if (timed_out) begin
      return;
    end
    repeat (halt_window) @(negedge clk);
    if (ar_count != 2 || retire_count != 2) begin
      errors++;
      $display("The core kept fetching after an illegal instruction");
    end

    test_name = "slverr";
    assert_reset();
    fill_memory();
    prog[0] = enc_i(1, 0, 3'd0, 1);
    prog[1] = enc_i(2, 0, 3'd0, 2);
    err_addr = 64'd4;
    release_reset();
    if (timed_out) begin
      return;
    end
    wait_retires(2);
    if (timed_out) begin
      return;
    end
    repeat (halt_window) @(negedge clk);
    if (ar_count != 2 || retire_count != 2) begin
      errors++;
      $display("The core kept fetching after an error response");
    end
  endtask

  initial begin
    run_tests();
    finish_run();
  end

endmodule

// File: test/clock_gen.sv
// Testbench clock and power-on reset generator.
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period.
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: source/core_top.sv
// Core top level: fetch, decode, execute and result stages on the AXI4-Lite read port.
`timescale 1ns/1ps

module core_top (
  input  logic                clk,
  input  logic                reset,
  output logic                arvalid,
  input  logic                arready,
  output core_pkg::axi_ar_t   ar,
  input  logic                rvalid,
  output logic                rready,
  input  core_pkg::axi_r_t    r,
  output logic                retire_valid,
  output core_pkg::retire_t   retire
);
  import core_pkg::*;

  fetch_out_t fetch_q;
  decode_out_t decode_q;
  exec_out_t exec_q;
  logic [4:0] rs1_addr;
  logic [4:0] rs2_addr;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;

  // The execute output closes the loop back to fetch.
  fetch_unit u_fetch (
    .clk            (clk),
    .reset          (reset),
    .redirect_valid (exec_q.valid),
    .redirect_pc    (exec_q.next_pc),
    .redirect_fault (exec_q.fault),
    .arvalid        (arvalid),
    .arready        (arready),
    .ar             (ar),
    .rvalid         (rvalid),
    .rready         (rready),
    .r              (r),
    .fetch_out      (fetch_q)
  );

  decode_unit u_decode (
    .clk        (clk),
    .reset      (reset),
    .fetch_in   (fetch_q),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .decode_out (decode_q)
  );

  execute_unit u_execute (
    .clk       (clk),
    .reset     (reset),
    .decode_in (decode_q),
    .exec_out  (exec_q)
  );

  result_unit u_result (
    .clk          (clk),
    .reset        (reset),
    .exec_in      (exec_q),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

// File: source/result_unit.sv
// Register file, writeback and retire report.
`timescale 1ns/1ps

module result_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  core_pkg::exec_out_t       exec_in,
  input  logic [4:0]                rs1_addr,
  input  logic [4:0]                rs2_addr,
  output logic [core_pkg::xlen-1:0] rs1_data,
  output logic [core_pkg::xlen-1:0] rs2_data,
  output logic                      retire_valid,
  output core_pkg::retire_t         retire
);
  import core_pkg::*;

  logic [xlen-1:0] regs [32];
  logic write_en;

  // A faulting instruction and a write to x0 leave the file untouched.
  assign write_en = exec_in.valid && exec_in.reg_write && !exec_in.fault &&
                    (exec_in.rd != 5'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[exec_in.rd] <= exec_in.result;
    end
  end

  // Reads are combinational. x0 is forced to zero on the read side.
  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= exec_in.valid;  // One pulse per instruction.
    end
  end

  always_ff @(posedge clk) begin
    retire.pc <= exec_in.pc;
    retire.rd <= exec_in.rd;
    retire.reg_write <= exec_in.reg_write && !exec_in.fault;
    retire.value <= exec_in.result;
    retire.next_pc <= exec_in.next_pc;
    retire.fault <= exec_in.fault;
  end

endmodule

// File: source/execute_unit.sv
// Execute stage: ALU, branch comparison and next-pc target for the fetch redirect.
`timescale 1ns/1ps

module execute_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  core_pkg::decode_out_t decode_in,
  output core_pkg::exec_out_t   exec_out
);
  import core_pkg::*;

  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] target;
  logic taken;
  exec_out_t exec_next;

  always_comb begin
    case (decode_in.alu_op)
      alu_add: alu_result = decode_in.op_a + decode_in.op_b;
      alu_sub: alu_result = decode_in.op_a - decode_in.op_b;
      alu_and: alu_result = decode_in.op_a & decode_in.op_b;
      alu_or: alu_result = decode_in.op_a | decode_in.op_b;
      alu_xor: alu_result = decode_in.op_a ^ decode_in.op_b;
      alu_slt: begin
        // Signed compare, the result is 0 or 1.
        alu_result = {{(xlen - 1){1'b0}},
                      $signed(decode_in.op_a) < $signed(decode_in.op_b)};
      end
      alu_pass_b: alu_result = decode_in.op_b;
      default: alu_result = '0;
    endcase
  end

  assign pc_plus4 = decode_in.pc + 64'd4;
  assign target = decode_in.pc + decode_in.imm;  // Branch and jump targets are pc relative.

  always_comb begin
    case (decode_in.branch)
      br_beq: taken = (decode_in.op_a == decode_in.cmp_val);
      br_bne: taken = (decode_in.op_a != decode_in.cmp_val);
      br_jal: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    exec_next.valid = decode_in.valid;
    exec_next.pc = decode_in.pc;
    exec_next.rd = decode_in.rd;
    exec_next.reg_write = decode_in.reg_write;
    exec_next.fault = decode_in.fault;
    exec_next.next_pc = taken ? target : pc_plus4;
    // JAL links the return address; everything else writes the ALU value.
    if (decode_in.branch == br_jal) begin
      exec_next.result = pc_plus4;
    end else begin
      exec_next.result = alu_result;
    end
  end

  // The registered result also serves as the redirect into fetch.
  always_ff @(posedge clk) begin
    exec_out <= exec_next;
    if (reset) begin
      exec_out.valid <= 1'b0;
    end
  end

endmodule

// File: source/decode_unit.sv
// Instruction decode: format selection, immediate generation and register read.
`timescale 1ns/1ps

module decode_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  core_pkg::fetch_out_t      fetch_in,
  output logic [4:0]                rs1_addr,
  output logic [4:0]                rs2_addr,
  input  logic [core_pkg::xlen-1:0] rs1_data,
  input  logic [core_pkg::xlen-1:0] rs2_data,
  output core_pkg::decode_out_t     decode_out
);
  import core_pkg::*;

  insn_u insn;
  decode_out_t decode_next;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;

  assign insn = fetch_in.insn;

  // Register fields sit at the same place in every format that has them.
  assign rs1_addr = insn.r_fmt.rs1;
  assign rs2_addr = insn.r_fmt.rs2;

  assign imm_i = {{52{insn.i_fmt.imm[11]}}, insn.i_fmt.imm};
  assign imm_u = {{32{insn.u_fmt.imm31_12[19]}}, insn.u_fmt.imm31_12, 12'b0};
  assign imm_b = {{51{insn.b_fmt.imm12}}, insn.b_fmt.imm12, insn.b_fmt.imm11,
                  insn.b_fmt.imm10_5, insn.b_fmt.imm4_1, 1'b0};
  assign imm_j = {{43{insn.j_fmt.imm20}}, insn.j_fmt.imm20, insn.j_fmt.imm19_12,
                  insn.j_fmt.imm11, insn.j_fmt.imm10_1, 1'b0};

  always_comb begin
    decode_next = '0;
    decode_next.valid = fetch_in.valid;
    decode_next.pc = fetch_in.pc;
    decode_next.rd = insn.r_fmt.rd;
    decode_next.alu_op = alu_add;
    decode_next.op_a = rs1_data;
    decode_next.op_b = rs2_data;
    decode_next.cmp_val = rs2_data;
    decode_next.branch = br_none;
    case (insn.r_fmt.opcode)
      opc_op: begin
        decode_next.reg_write = 1'b1;
        case ({insn.r_fmt.funct7, insn.r_fmt.funct3})
          10'b0000000_000: decode_next.alu_op = alu_add;
          10'b0100000_000: decode_next.alu_op = alu_sub;
          10'b0000000_010: decode_next.alu_op = alu_slt;
          10'b0000000_100: decode_next.alu_op = alu_xor;
          10'b0000000_110: decode_next.alu_op = alu_or;
          10'b0000000_111: decode_next.alu_op = alu_and;
          default: decode_next.fault = 1'b1;
        endcase
      end
      opc_op_imm: begin
        decode_next.reg_write = 1'b1;
        decode_next.imm = imm_i;
        decode_next.op_b = imm_i;
        case (insn.i_fmt.funct3)
          3'b000: decode_next.alu_op = alu_add;
          3'b100: decode_next.alu_op = alu_xor;
          3'b110: decode_next.alu_op = alu_or;
          3'b111: decode_next.alu_op = alu_and;
          default: decode_next.fault = 1'b1;  // SLTI, shifts and friends are not supported.
        endcase
      end
      opc_lui: begin
        decode_next.reg_write = 1'b1;
        decode_next.alu_op = alu_pass_b;
        decode_next.imm = imm_u;
        decode_next.op_b = imm_u;
      end
      opc_branch: begin
        decode_next.imm = imm_b;
        case (insn.b_fmt.funct3)
          3'b000: decode_next.branch = br_beq;
          3'b001: decode_next.branch = br_bne;
          default: decode_next.fault = 1'b1;
        endcase
      end
      opc_jal: begin
        decode_next.reg_write = 1'b1;
        decode_next.imm = imm_j;
        decode_next.branch = br_jal;
      end
      default: decode_next.fault = 1'b1;
    endcase
    if (decode_next.fault) begin
      decode_next.reg_write = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    decode_out <= decode_next;
    if (reset) begin
      decode_out.valid <= 1'b0;
    end
  end

endmodule

// File: source/fetch_unit.sv
// Instruction fetch: pc register, next-pc load, AXI4-Lite read master and fault hold.
`timescale 1ns/1ps

module fetch_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    redirect_valid,
  input  logic [core_pkg::xlen-1:0] redirect_pc,
  input  logic                    redirect_fault,
  output logic                    arvalid,
  input  logic                    arready,
  output core_pkg::axi_ar_t       ar,
  input  logic                    rvalid,
  output logic                    rready,
  input  core_pkg::axi_r_t        r,
  output core_pkg::fetch_out_t    fetch_out
);
  import core_pkg::*;

  // Issue drives AR, wait accepts R, idle waits for execute to resolve the next pc.
  typedef enum logic [1:0] {
    st_issue,
    st_wait,
    st_idle
  } fetch_state_t;

  fetch_state_t state;
  logic [xlen-1:0] pc;
  logic halted;  // Set by a faulting instruction and never cleared until reset.

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_issue;  // The first read goes out as soon as reset drops.
      pc <= reset_pc;
      halted <= 1'b0;
    end else begin
      case (state)
        st_issue: begin
          if (arready) begin
            state <= st_wait;
          end
        end
        st_wait: begin
          if (rvalid) begin
            state <= st_idle;
          end
        end
        st_idle: begin
          // Execute hands back the resolved next pc one cycle before retire.
          if (redirect_valid && !halted) begin
            pc <= redirect_pc;
            halted <= redirect_fault;
            if (!redirect_fault) begin
              state <= st_issue;
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // The address stays on the bus unchanged until arready, since pc only moves in idle.
  assign arvalid = (state == st_issue);
  assign ar.araddr = pc;
  assign ar.arprot = insn_arprot;

  assign rready = (state == st_wait);  // High only while the read is outstanding.

  // The response goes straight to decode in the handshake cycle.
  // An error response becomes an all-zero word, which decode rejects.
  assign fetch_out.valid = rvalid && rready;
  assign fetch_out.pc = pc;
  assign fetch_out.insn = (r.rresp == resp_okay) ? r.rdata : '0;

endmodule

// File: source/core_pkg.sv
// Core widths, opcodes, instruction union, and stage and bus structs.
package core_pkg;

  localparam int xlen = 64;  // Register and pc width.
  localparam int ilen = 32;  // Instruction word width.
  localparam logic [xlen-1:0] reset_pc = '0;

  // Major opcodes of the supported RV64I groups.
  localparam logic [6:0] opc_op = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal = 7'b1101111;

  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [2:0] insn_arprot = 3'b100;  // Instruction, secure, unprivileged.

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_t;

  typedef enum logic [1:0] {
    br_none,
    br_beq,
    br_bne,
    br_jal
  } branch_t;

  // One packed view per instruction format, all of them ilen bits wide.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } i_fmt_t;

  typedef struct packed {
    logic imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } u_fmt_t;

  typedef struct packed {
    logic imm20;
    logic [9:0] imm10_1;
    logic imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } insn_u;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] pc;
    insn_u insn;
  } fetch_out_t;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] pc;
    logic [4:0] rd;
    logic reg_write;
    alu_op_t alu_op;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] cmp_val;  // Second branch operand.
    branch_t branch;
    logic [xlen-1:0] imm;
    logic fault;
  } decode_out_t;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] pc;
    logic [4:0] rd;
    logic reg_write;
    logic [xlen-1:0] result;
    logic [xlen-1:0] next_pc;
    logic fault;
  } exec_out_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [4:0] rd;
    logic reg_write;
    logic [xlen-1:0] value;
    logic [xlen-1:0] next_pc;
    logic fault;
  } retire_t;

  typedef struct packed {
    logic [xlen-1:0] araddr;
    logic [2:0] arprot;
  } axi_ar_t;

  typedef struct packed {
    logic [ilen-1:0] rdata;
    logic [1:0] rresp;
  } axi_r_t;

endpackage
